// File: verilog/mem_op_pkg.sv
package mem_op_pkg;

    typedef enum logic [1:0] {
        op_pass  = 2'b00,  // Forward result unchanged
        op_load  = 2'b01,
        op_store = 2'b10
    } mem_op_t;

    localparam int cache_lines      = 16;
    localparam int cache_index_bits = $clog2(cache_lines);
    localparam int cache_tag_bits   = 26;

    // The cache splits the word into fields, the bus master uses it flat
    typedef union packed {
        struct packed {
            logic [cache_tag_bits-1:0]   tag;
            logic [cache_index_bits-1:0] index;
            logic [1:0]                  offset;  // Byte within word
        } cache;
        logic [31:0] flat;
    } mem_addr_u;

endpackage

// File: verilog/ahb_pkg.sv
package ahb_pkg;

    typedef enum logic [1:0] {
        htrans_idle   = 2'b00,
        htrans_nonseq = 2'b10  // Single transfers only
    } htrans_t;

    localparam logic [2:0] hsize_word = 3'b010;

endpackage

// File: verilog/data_cache.sv
`timescale 1ns/1ps

module data_cache (
    input  logic                  clk,
    input  logic                  reset,
    input  mem_op_pkg::mem_addr_u lookup_addr,
    input  logic                  fill,
    input  logic [31:0]           fill_data,
    input  logic                  update,
    input  logic [31:0]           update_data,
    output logic                  hit,
    output logic [31:0]           rdata
);

    import mem_op_pkg::*;

    logic [cache_lines-1:0]      valid;
    logic [cache_tag_bits-1:0]   tag_q  [cache_lines];
    logic [31:0]                 data_q [cache_lines];
    logic [cache_index_bits-1:0] idx;

    // Fills and updates target the line of the current lookup address
    assign idx   = lookup_addr.cache.index;
    assign hit   = valid[idx] && (tag_q[idx] == lookup_addr.cache.tag);
    assign rdata = data_q[idx];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            valid <= '0;
        end else if (fill) begin
            valid[idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (fill) begin
            tag_q[idx]  <= lookup_addr.cache.tag;
            data_q[idx] <= fill_data;
        end else if (update) begin
            data_q[idx] <= update_data;  // Tag already matches on a hit
        end
    end

endmodule

// File: verilog/ahb_master.sv
`timescale 1ns/1ps

module ahb_master (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  xfer_start,
    input  logic                  xfer_write,
    input  mem_op_pkg::mem_addr_u xfer_addr,
    input  logic [31:0]           xfer_wdata,
    input  logic [31:0]           hrdata,
    input  logic                  hready,
    output logic                  xfer_done,
    output logic [31:0]           xfer_rdata,
    output logic [31:0]           haddr,
    output ahb_pkg::htrans_t      htrans,
    output logic                  hwrite,
    output logic [2:0]            hsize,
    output logic [31:0]           hwdata
);

    import ahb_pkg::*;

    localparam logic [1:0] st_idle = 2'd0;
    localparam logic [1:0] st_addr = 2'd1;
    localparam logic [1:0] st_data = 2'd2;

    logic [1:0] state;

    assign hsize = hsize_word;  // Word transfers only

    // Read data is taken by the stage in the cycle hready completes the data phase
    assign xfer_done  = (state == st_data) && hready;
    assign xfer_rdata = hrdata;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state  <= st_idle;
            htrans <= htrans_idle;
            hwrite <= 1'b0;
        end else begin
            case (state)
                st_idle: begin
                    if (xfer_start) begin
                        state  <= st_addr;
                        htrans <= htrans_nonseq;
                        hwrite <= xfer_write;
                    end
                end
                st_addr: begin
                    state  <= st_data;
                    htrans <= htrans_idle;  // Single transfer, nothing follows
                end
                st_data: begin
                    if (hready) begin
                        state <= st_idle;
                    end
                end
                default: begin
                    state  <= st_idle;
                    htrans <= htrans_idle;
                end
            endcase
        end
    end

    // Address and write data are held until the data phase ends
    always_ff @(posedge clk) begin
        if ((state == st_idle) && xfer_start) begin
            haddr  <= xfer_addr.flat;
            hwdata <= xfer_wdata;
        end
    end

endmodule

// File: verilog/mem_stage.sv
`timescale 1ns/1ps

module mem_stage #(
    parameter int queue_depth = 4
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  req_valid,
    input  mem_op_pkg::mem_op_t   req_op,
    input  mem_op_pkg::mem_addr_u req_addr,
    input  logic [31:0]           req_wdata,
    input  logic [4:0]            req_rd,
    input  logic                  req_reg_write,
    input  logic                  hit,
    input  logic [31:0]           rdata,
    input  logic                  xfer_done,
    input  logic [31:0]           xfer_rdata,
    output logic                  credit_return,
    output mem_op_pkg::mem_addr_u lookup_addr,
    output logic                  fill,
    output logic [31:0]           fill_data,
    output logic                  update,
    output logic [31:0]           update_data,
    output logic                  xfer_start,
    output logic                  xfer_write,
    output mem_op_pkg::mem_addr_u xfer_addr,
    output logic [31:0]           xfer_wdata,
    output logic                  wb_valid,
    output logic [4:0]            wb_rd,
    output logic [31:0]           wb_data,
    output logic                  wb_reg_write
);

    import mem_op_pkg::*;

    localparam int ptr_bits   = (queue_depth > 1) ? $clog2(queue_depth) : 1;
    localparam int count_bits = $clog2(queue_depth + 1);

    localparam logic [1:0] st_idle   = 2'd0;
    localparam logic [1:0] st_lookup = 2'd1;  // Head is checked against the cache
    localparam logic [1:0] st_bus    = 2'd2;  // Waiting for the bus master

    mem_op_t     q_op        [queue_depth];
    mem_addr_u   q_addr      [queue_depth];
    logic [31:0] q_wdata     [queue_depth];
    logic [4:0]  q_rd        [queue_depth];
    logic        q_reg_write [queue_depth];

    logic [ptr_bits-1:0]   wr_ptr;
    logic [ptr_bits-1:0]   rd_ptr;
    logic [count_bits-1:0] count;
    logic [count_bits-1:0] count_next;
    logic [1:0]            state;

    mem_op_t     head_op;
    logic        is_load;
    logic        is_store;
    logic        needs_bus;
    logic        retire;
    logic [31:0] retire_data;

    function automatic logic [ptr_bits-1:0] ptr_inc(input logic [ptr_bits-1:0] ptr);
        ptr_inc = (ptr == ptr_bits'(queue_depth - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign head_op   = q_op[rd_ptr];
    assign is_load   = (head_op == op_load);
    assign is_store  = (head_op == op_store);
    assign needs_bus = is_store || (is_load && !hit);  // Stores always write through

    assign lookup_addr = q_addr[rd_ptr];
    assign xfer_start  = (state == st_lookup) && needs_bus;
    assign xfer_write  = is_store;
    assign xfer_addr   = q_addr[rd_ptr];
    assign xfer_wdata  = q_wdata[rd_ptr];

    // Line update on a store hit, fill on a completed load miss
    assign update      = (state == st_lookup) && is_store && hit;
    assign update_data = q_wdata[rd_ptr];
    assign fill        = (state == st_bus) && xfer_done && is_load;
    assign fill_data   = xfer_rdata;

    assign retire     = ((state == st_lookup) && !needs_bus) || ((state == st_bus) && xfer_done);
    assign count_next = count + count_bits'(req_valid) - count_bits'(retire);

    always_comb begin
        if (is_store) begin
            retire_data = '0;
        end else if (state == st_bus) begin
            retire_data = xfer_rdata;  // Load miss
        end else if (is_load) begin
            retire_data = rdata;
        end else begin
            retire_data = q_addr[rd_ptr].flat;  // Pass carries the result here
        end
    end

    always_ff @(posedge clk) begin
        if (req_valid) begin
            q_op[wr_ptr]        <= req_op;
            q_addr[wr_ptr]      <= req_addr;
            q_wdata[wr_ptr]     <= req_wdata;
            q_rd[wr_ptr]        <= req_rd;
            q_reg_write[wr_ptr] <= req_reg_write;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wr_ptr        <= '0;
            rd_ptr        <= '0;
            count         <= '0;
            state         <= st_idle;
            wb_valid      <= 1'b0;
            credit_return <= 1'b0;
        end else begin
            if (req_valid) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (retire) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            count         <= count_next;
            wb_valid      <= retire;
            credit_return <= retire;  // Same cycle as wb_valid
            case (state)
                st_idle: begin
                    if (count_next != '0) begin
                        state <= st_lookup;
                    end
                end
                st_lookup: begin
                    if (needs_bus) begin
                        state <= st_bus;
                    end else begin
                        state <= (count_next != '0) ? st_lookup : st_idle;
                    end
                end
                st_bus: begin
                    if (xfer_done) begin
                        state <= (count_next != '0) ? st_lookup : st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (retire) begin
            wb_rd        <= q_rd[rd_ptr];
            wb_reg_write <= q_reg_write[rd_ptr];
            wb_data      <= retire_data;
        end
    end

endmodule

// File: verilog/mem_subsystem.sv
`timescale 1ns/1ps

module mem_subsystem #(
    parameter int queue_depth = 4
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  req_valid,
    input  mem_op_pkg::mem_op_t   req_op,
    input  mem_op_pkg::mem_addr_u req_addr,
    input  logic [31:0]           req_wdata,
    input  logic [4:0]            req_rd,
    input  logic                  req_reg_write,
    output logic                  credit_return,
    output logic                  wb_valid,
    output logic [4:0]            wb_rd,
    output logic [31:0]           wb_data,
    output logic                  wb_reg_write,
    output logic [31:0]           haddr,
    output ahb_pkg::htrans_t      htrans,
    output logic                  hwrite,
    output logic [2:0]            hsize,
    output logic [31:0]           hwdata,
    input  logic [31:0]           hrdata,
    input  logic                  hready
);

    import mem_op_pkg::*;

    mem_addr_u   lookup_addr;
    mem_addr_u   xfer_addr;
    logic        hit;
    logic        fill;
    logic        update;
    logic        xfer_start;
    logic        xfer_write;
    logic        xfer_done;
    logic [31:0] rdata;
    logic [31:0] fill_data;
    logic [31:0] update_data;
    logic [31:0] xfer_wdata;
    logic [31:0] xfer_rdata;

    mem_stage #(
        .queue_depth(queue_depth)
    ) i_stage (
        .clk          (clk),
        .reset        (reset),
        .req_valid    (req_valid),
        .req_op       (req_op),
        .req_addr     (req_addr),
        .req_wdata    (req_wdata),
        .req_rd       (req_rd),
        .req_reg_write(req_reg_write),
        .hit          (hit),
        .rdata        (rdata),
        .xfer_done    (xfer_done),
        .xfer_rdata   (xfer_rdata),
        .credit_return(credit_return),
        .lookup_addr  (lookup_addr),
        .fill         (fill),
        .fill_data    (fill_data),
        .update       (update),
        .update_data  (update_data),
        .xfer_start   (xfer_start),
        .xfer_write   (xfer_write),
        .xfer_addr    (xfer_addr),
        .xfer_wdata   (xfer_wdata),
        .wb_valid     (wb_valid),
        .wb_rd        (wb_rd),
        .wb_data      (wb_data),
        .wb_reg_write (wb_reg_write)
    );

    data_cache i_cache (
        .clk        (clk),
        .reset      (reset),
        .lookup_addr(lookup_addr),
        .fill       (fill),
        .fill_data  (fill_data),
        .update     (update),
        .update_data(update_data),
        .hit        (hit),
        .rdata      (rdata)
    );

    ahb_master i_master (
        .clk       (clk),
        .reset     (reset),
        .xfer_start(xfer_start),
        .xfer_write(xfer_write),
        .xfer_addr (xfer_addr),
        .xfer_wdata(xfer_wdata),
        .hrdata    (hrdata),
        .hready    (hready),
        .xfer_done (xfer_done),
        .xfer_rdata(xfer_rdata),
        .haddr     (haddr),
        .htrans    (htrans),
        .hwrite    (hwrite),
        .hsize     (hsize),
        .hwdata    (hwdata)
    );

endmodule

// File: tests/ahb_slave_model.sv
`timescale 1ns/1ps

module ahb_slave_model (
    input  logic             clk,
    input  logic             reset,
    input  logic [31:0]      haddr,
    input  ahb_pkg::htrans_t htrans,
    input  logic             hwrite,
    input  logic [31:0]      hwdata,
    input  logic [1:0]       wait_cycles,
    output logic [31:0]      hrdata,
    output logic             hready,
    output logic             seen_valid,
    output logic             seen_write,
    output logic [31:0]      seen_addr,
    output logic [31:0]      seen_data
);

    import ahb_pkg::*;

    logic [31:0] mem [256];
    logic        active;
    logic        write_q;
    logic [31:0] addr_q;
    logic [1:0]  wait_cnt;

    initial begin
        for (int i = 0; i < 256; i++) begin
            mem[i] = {4{8'(i)}} ^ 32'h5ac3_0f96;  // Distinct word per address
        end
    end

    assign hready     = !active || (wait_cnt == 2'd0);
    assign hrdata     = mem[addr_q[9:2]];
    assign seen_valid = active && hready;  // Data phase completes this cycle
    assign seen_write = write_q;
    assign seen_addr  = addr_q;
    assign seen_data  = write_q ? hwdata : hrdata;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            active   <= 1'b0;
            write_q  <= 1'b0;
            addr_q   <= '0;
            wait_cnt <= '0;
        end else if (active && (wait_cnt != 2'd0)) begin
            wait_cnt <= wait_cnt - 1'b1;
        end else begin
            active <= (htrans == htrans_nonseq);
            if (htrans == htrans_nonseq) begin
                addr_q   <= haddr;
                write_q  <= hwrite;
                wait_cnt <= wait_cycles;  // Wait states for this transfer
            end
        end
    end

    always @(posedge clk) begin
        if (seen_valid && write_q) begin
            mem[addr_q[9:2]] <= hwdata;
        end
    end

endmodule

// File: tests/tb_mem_subsystem.sv
`timescale 1ns/1ps

module tb_mem_subsystem;

    import mem_op_pkg::*;
    import ahb_pkg::*;

    localparam int depth       = 4;
    localparam int half_period = 2;    // 4 ns clock
    localparam int total_ops   = 400;  // Sum of all test lengths

    logic        clk = 1'b0;
    logic        reset;
    logic        req_valid;
    mem_op_t     req_op;
    mem_addr_u   req_addr;
    logic [31:0] req_wdata;
    logic [4:0]  req_rd;
    logic        req_reg_write;
    logic        credit_return;
    logic        wb_valid;
    logic [4:0]  wb_rd;
    logic [31:0] wb_data;
    logic        wb_reg_write;
    logic [31:0] haddr;
    htrans_t     htrans;
    logic        hwrite;
    logic [2:0]  hsize;
    logic [31:0] hwdata;
    logic [31:0] hrdata;
    logic        hready;
    logic [1:0]  wait_cycles;
    logic        seen_valid;
    logic        seen_write;
    logic [31:0] seen_addr;
    logic [31:0] seen_data;

    logic [37:0] exp_wb [$];   // reg_write, rd, data
    logic [64:0] exp_bus [$];  // write, addr, data
    logic [37:0] wb_exp;
    logic [64:0] bus_exp;
    logic [31:0] shadow_mem [256];
    logic        line_valid [16];
    logic [7:0]  line_word [16];  // Word resident in each line
    logic        evicted [256];
    logic [31:0] stim_state = 32'h68df;
    int credits = depth;
    int issued = 0;
    int retired = 0;
    int returns = 0;
    int checks = 0;
    int errors = 0;
    int test_num = 0;
    int test_checks;
    int test_errors;
    int hits;
    int refills;

    mem_subsystem #(.queue_depth(depth)) i_dut (.*);
    ahb_slave_model i_slave (.*);

    always #(half_period) clk = ~clk;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] next_rand();
        stim_state = xorshift(stim_state);
        return stim_state;
    endfunction

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] want);
        checks++;
        assert (got === want) else begin
            $display("[ERROR] %s is %h, expected %h", name, got, want);
            errors++;
        end
    endtask

    task automatic check_condition(input bit cond, input string what);
        checks++;
        assert (cond) else begin
            $display("Check failed: %s", what);
            errors++;
        end
    endtask

    task automatic start_test();
        test_num++;
        test_checks = checks;
        test_errors = errors;
    endtask

    task automatic close_test(input string name);
        $display("test %0d %s: %0d checks, %0d errors", test_num, name,
                 checks - test_checks, errors - test_errors);
    endtask

    // Expected writeback and bus traffic, in issue order
    task automatic model_op(input mem_op_t op, input logic [31:0] addr, input logic [31:0] data,
                            input logic [4:0] rd, input logic reg_write);
        logic [7:0] w;
        logic [3:0] line;
        w    = addr[9:2];
        line = addr[5:2];
        if (op == op_pass) begin
            exp_wb.push_back({reg_write, rd, addr});
        end else if (op == op_load) begin
            if (line_valid[line] && (line_word[line] == w)) begin
                hits++;
            end else begin
                if (evicted[w]) begin
                    refills++;
                end
                if (line_valid[line]) begin
                    evicted[line_word[line]] = 1'b1;
                end
                evicted[w]       = 1'b0;
                line_valid[line] = 1'b1;
                line_word[line]  = w;
                exp_bus.push_back({1'b0, addr, shadow_mem[w]});
            end
            exp_wb.push_back({reg_write, rd, shadow_mem[w]});
        end else begin
            shadow_mem[w] = data;  // Write-through, no allocate on miss
            exp_bus.push_back({1'b1, addr, data});
            exp_wb.push_back({reg_write, rd, 32'h0});
        end
    endtask

    // Mode 0 pass only, 1 loads and stores, 2 all kinds
    task automatic run_ops(input int n, input int mode, input logic [7:0] word_mask);
        int          count;
        logic [31:0] r;
        logic [31:0] payload;
        logic [31:0] addr;
        mem_op_t     op;
        count = 0;
        while (count < n) begin
            @(posedge clk);
            r = next_rand();
            wait_cycles <= r[31:30];
            if ((credits > 0) && r[0]) begin
                payload = next_rand();
                if (mode == 0) begin
                    op = op_pass;
                end else if (mode == 1) begin
                    op = r[1] ? op_store : op_load;
                end else begin
                    op = (r[3:2] == 2'd0) ? op_pass : ((r[3:2] == 2'd3) ? op_store : op_load);
                end
                addr = (op == op_pass) ? payload : {22'b0, r[15:8] & word_mask, 2'b00};
                req_valid     <= 1'b1;
                req_op        <= op;
                req_addr.flat <= addr;
                req_wdata     <= payload;
                req_rd        <= r[20:16];
                req_reg_write <= r[21];
                model_op(op, addr, payload, r[20:16], r[21]);
                credits--;
                issued++;
                count++;
            end else begin
                req_valid <= 1'b0;
            end
        end
        @(posedge clk);
        req_valid <= 1'b0;
        while (retired != issued) begin
            @(posedge clk);
            r = next_rand();
            wait_cycles <= r[1:0];
        end
    endtask

    always @(negedge clk) begin
        if (!reset) begin
            if (credit_return) begin
                credits++;
                returns++;
            end
            if (wb_valid || credit_return) begin
                compare_value("credit_return", credit_return, wb_valid);
            end
            if (wb_valid) begin
                retired++;
                check_condition(exp_wb.size() != 0, "writeback with no operation pending");
                if (exp_wb.size() != 0) begin
                    wb_exp = exp_wb.pop_front();
                    compare_value("wb_data", wb_data, wb_exp[31:0]);
                    compare_value("wb_rd", 32'(wb_rd), 32'(wb_exp[36:32]));
                    compare_value("wb_reg_write", 32'(wb_reg_write), 32'(wb_exp[37]));
                end
            end
            if (seen_valid) begin
                check_condition(exp_bus.size() != 0, "bus transfer that no operation needs");
                if (exp_bus.size() != 0) begin
                    bus_exp = exp_bus.pop_front();
                    compare_value("hwrite", 32'(seen_write), 32'(bus_exp[64]));
                    compare_value("haddr", seen_addr, bus_exp[63:32]);
                    compare_value(bus_exp[64] ? "hwdata" : "hrdata", seen_data, bus_exp[31:0]);
                end
            end
            if (htrans == htrans_nonseq) begin
                compare_value("hsize", 32'(hsize), 32'h2);
            end
            check_condition((issued - retired) <= depth, "more operations outstanding than depth");
        end
    end

    initial begin
        #(total_ops * 40 * 2 * half_period);
        $display("Watchdog expired with %0d of %0d operations retired", retired, issued);
        $display("*** FAILED ***");
        $finish;
    end

    initial begin
        reset         = 1'b1;
        req_valid     = 1'b0;
        req_op        = op_pass;
        req_addr      = '0;
        req_wdata     = '0;
        req_rd        = '0;
        req_reg_write = 1'b0;
        wait_cycles   = 2'd0;
        for (int i = 0; i < 16; i++) begin
            line_valid[i] = 1'b0;
        end
        for (int i = 0; i < 256; i++) begin
            evicted[i] = 1'b0;
        end
        repeat (4) @(posedge clk);
        reset <= 1'b0;
        for (int i = 0; i < 256; i++) begin
            shadow_mem[i] = i_slave.mem[i];  // Slave starts from its fill pattern
        end

        start_test();
        repeat (3) begin
            @(negedge clk);
            compare_value("wb_valid", 32'(wb_valid), 32'h0);
            compare_value("credit_return", 32'(credit_return), 32'h0);
            compare_value("htrans", 32'(htrans), 32'(htrans_idle));
        end
        close_test("reset state");

        start_test();
        run_ops(40, 0, 8'hff);
        close_test("pass operations");

        start_test();
        run_ops(120, 1, 8'hff);
        close_test("stores and loads");

        start_test();
        hits    = 0;
        refills = 0;
        run_ops(120, 1, 8'h1f);  // Two words per line, frequent evictions
        check_condition(hits > 0, "no load hit the cache");
        check_condition(refills > 0, "no evicted word was loaded again");
        close_test("cache behavior");

        start_test();
        run_ops(120, 2, 8'hff);
        compare_value("credit returns", returns, retired);
        compare_value("credits held", credits, depth);
        compare_value("pending writebacks", exp_wb.size(), 0);
        compare_value("pending bus transfers", exp_bus.size(), 0);
        close_test("credit accounting");

        $display("%0d tests, %0d checks, %0d errors", test_num, checks, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// File: verilog.f
verilog/mem_op_pkg.sv
verilog/ahb_pkg.sv
verilog/data_cache.sv
verilog/ahb_master.sv
verilog/mem_stage.sv
verilog/mem_subsystem.sv
tests/ahb_slave_model.sv
tests/tb_mem_subsystem.sv
